// ==== Bender.yml ====
package:
  name: issue_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/issue_pkg.sv
      - rtl/issue_regfile.sv
      - rtl/issue_scoreboard.sv
      - rtl/issue_dispatch.sv
      - rtl/issue_skid_buffer.sv
      - rtl/issue_stage.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/issue_tb.sv

// ==== include/issue_cfg.svh ====
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// Width of one architectural register and of pc/imm values
`define ISSUE_XLEN 32

// Number of integer registers, x0 included
`define ISSUE_REG_COUNT 32

// Bits needed to address one register
`define ISSUE_REG_ADDR_W 5

`endif

// ==== rtl/issue_dispatch.sv ====
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_dispatch (
  input  logic                     clk_core,
  input  logic                     rst_core_n,
  input  logic                     flush_i,
  input  issue_pkg::issue_instr_t  instr_i,
  input  logic                     advance_i,
  input  logic [`ISSUE_XLEN-1:0]   rs1_data_i,
  input  logic [`ISSUE_XLEN-1:0]   rs2_data_i,
  input  logic                     alu_ready_i,
  input  logic                     branch_ready_i,
  input  logic                     mem_ready_i,
  output logic                     free_o,
  output issue_pkg::alu_data_t     alu_data_o,
  output logic                     alu_valid_o,
  output issue_pkg::branch_data_t  branch_data_o,
  output logic                     branch_valid_o,
  output issue_pkg::mem_data_t     mem_data_o,
  output logic                     mem_valid_o
);

  logic                    d_valid;
  issue_pkg::unit_e        d_unit;
  logic [2:0]              d_op;
  logic                    d_writes_rd;
  logic                    d_use_imm;
  issue_pkg::exec_common_t d_common;
  logic                    tgt_ready;

  // Ready of the buffer this entry is headed for
  always_comb begin
    case (d_unit)
      issue_pkg::UNIT_ALU:    tgt_ready = alu_ready_i;
      issue_pkg::UNIT_BRANCH: tgt_ready = branch_ready_i;
      issue_pkg::UNIT_MEM:    tgt_ready = mem_ready_i;
      default:                tgt_ready = 1'b1;
    endcase
  end

  assign free_o = ~d_valid | tgt_ready;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      d_valid <= 1'b0;
    end else if (flush_i) begin
      d_valid <= 1'b0;
    end else if (advance_i) begin
      d_valid <= 1'b1;
    end else if (tgt_ready) begin
      d_valid <= 1'b0;
    end
  end

  // Operands are sampled at the advance edge
  always_ff @(posedge clk_core) begin
    if (advance_i) begin
      d_unit           <= instr_i.unit;
      d_op             <= instr_i.op;
      d_writes_rd      <= instr_i.writes_rd;
      d_use_imm        <= instr_i.use_imm;
      d_common.rs1     <= rs1_data_i;
      d_common.rs2     <= rs2_data_i;
      d_common.pc      <= instr_i.pc;
      d_common.imm     <= instr_i.imm;
      d_common.rd_addr <= instr_i.rd_addr;
    end
  end

  always_comb begin
    alu_data_o.op            = issue_pkg::alu_op_e'(d_op);
    alu_data_o.use_imm       = d_use_imm;
    alu_data_o.common        = d_common;
    branch_data_o.op         = issue_pkg::branch_op_e'(d_op);
    branch_data_o.writes_rd  = d_writes_rd;
    branch_data_o.common     = d_common;
    mem_data_o.op            = issue_pkg::mem_op_e'(d_op);
    mem_data_o.writes_rd     = d_writes_rd;
    mem_data_o.common        = d_common;
  end

  assign alu_valid_o    = d_valid & (d_unit == issue_pkg::UNIT_ALU);
  assign branch_valid_o = d_valid & (d_unit == issue_pkg::UNIT_BRANCH);
  assign mem_valid_o    = d_valid & (d_unit == issue_pkg::UNIT_MEM);

endmodule

// ==== rtl/issue_pkg.sv ====
`include "issue_cfg.svh"

package issue_pkg;

  // Execution unit selected by decode
  typedef enum logic [1:0] {
    UNIT_ALU    = 2'd0,
    UNIT_BRANCH = 2'd1,
    UNIT_MEM    = 2'd2
  } unit_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_SLL = 3'd6,
    ALU_SRL = 3'd7
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'd0,
    BR_BNE  = 3'd1,
    BR_BLT  = 3'd2,
    BR_BGE  = 3'd3,
    BR_JAL  = 3'd4,
    BR_JALR = 3'd5
  } branch_op_e;

  typedef enum logic [2:0] {
    MEM_LB = 3'd0,
    MEM_LH = 3'd1,
    MEM_LW = 3'd2,
    MEM_SB = 3'd3,
    MEM_SH = 3'd4,
    MEM_SW = 3'd5
  } mem_op_e;

  // Decoded instruction as it arrives from decode
  typedef struct packed {
    unit_e                        unit;
    // Raw opcode, meaning depends on unit
    logic [2:0]                   op;
    logic                         writes_rd;
    logic [`ISSUE_REG_ADDR_W-1:0] rd_addr;
    logic [`ISSUE_REG_ADDR_W-1:0] rs1_addr;
    logic [`ISSUE_REG_ADDR_W-1:0] rs2_addr;
    logic [`ISSUE_XLEN-1:0]       pc;
    logic [`ISSUE_XLEN-1:0]       imm;
    logic                         use_imm;
  } issue_instr_t;

  // Fields shared by every execution unit
  typedef struct packed {
    logic [`ISSUE_XLEN-1:0]       rs1;
    logic [`ISSUE_XLEN-1:0]       rs2;
    logic [`ISSUE_XLEN-1:0]       pc;
    logic [`ISSUE_XLEN-1:0]       imm;
    logic [`ISSUE_REG_ADDR_W-1:0] rd_addr;
  } exec_common_t;

  typedef struct packed {
    alu_op_e      op;
    logic         use_imm;
    exec_common_t common;
  } alu_data_t;

  typedef struct packed {
    branch_op_e   op;
    logic         writes_rd;
    exec_common_t common;
  } branch_data_t;

  typedef struct packed {
    mem_op_e      op;
    logic         writes_rd;
    exec_common_t common;
  } mem_data_t;

endpackage

// ==== rtl/issue_regfile.sv ====
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_regfile (
  input  logic                         clk_core,
  input  logic                         rst_core_n,
  input  logic [`ISSUE_REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0] wr_addr_i,
  input  logic [`ISSUE_XLEN-1:0]       wr_data_i,
  input  logic                         wr_en_i,
  output logic [`ISSUE_XLEN-1:0]       rs1_data_o,
  output logic [`ISSUE_XLEN-1:0]       rs2_data_o
);

  logic [`ISSUE_XLEN-1:0] regs [`ISSUE_REG_COUNT];

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 0; i < `ISSUE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // x0 reads zero; a same-cycle write is forwarded to the readers
  always_comb begin
    if (rs1_addr_i == '0) begin
      rs1_data_o = '0;
    end else if (wr_en_i && (wr_addr_i == rs1_addr_i)) begin
      rs1_data_o = wr_data_i;
    end else begin
      rs1_data_o = regs[rs1_addr_i];
    end

    if (rs2_addr_i == '0) begin
      rs2_data_o = '0;
    end else if (wr_en_i && (wr_addr_i == rs2_addr_i)) begin
      rs2_data_o = wr_data_i;
    end else begin
      rs2_data_o = regs[rs2_addr_i];
    end
  end

endmodule

// ==== rtl/issue_scoreboard.sv ====
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_scoreboard (
  input  logic                          clk_core,
  input  logic                          rst_core_n,
  input  logic                          flush_i,
  input  issue_pkg::issue_instr_t       instr_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  input  logic                          dispatch_free_i,
  input  logic                          wr_en_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0]  wr_addr_i,
  output issue_pkg::issue_instr_t       instr_o,
  output logic                          valid_o,
  output logic                          advance_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]  rs1_addr_o,
  output logic [`ISSUE_REG_ADDR_W-1:0]  rs2_addr_o
);

  issue_pkg::issue_instr_t held_instr;
  logic                    held_valid;

  // One pending bit per destination register
  logic [`ISSUE_REG_COUNT-1:0] pending;
  logic [`ISSUE_REG_COUNT-1:0] wr_clear;
  logic [`ISSUE_REG_COUNT-1:0] rd_set;
  logic [`ISSUE_REG_COUNT-1:0] pending_eff;
  logic                        hazard;
  logic                        accept;

  always_comb begin
    wr_clear = '0;
    if (wr_en_i) begin
      wr_clear[wr_addr_i] = 1'b1;
    end
    rd_set = '0;
    if (advance_o && held_instr.writes_rd && (held_instr.rd_addr != '0)) begin
      rd_set[held_instr.rd_addr] = 1'b1;
    end
  end

  // A register written back this cycle no longer blocks
  assign pending_eff = pending & ~wr_clear;

  assign hazard = pending_eff[held_instr.rs1_addr] | pending_eff[held_instr.rs2_addr];

  assign advance_o = held_valid & ~hazard & dispatch_free_i;
  assign ready_o   = ~flush_i & (~held_valid | advance_o);
  assign accept    = valid_i & ready_o;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      held_valid <= 1'b0;
      pending    <= '0;
    end else if (flush_i) begin
      held_valid <= 1'b0;
      pending    <= '0;
    end else begin
      // Set wins over a clear of the same register
      pending <= (pending & ~wr_clear) | rd_set;
      if (accept) begin
        held_valid <= 1'b1;
      end else if (advance_o) begin
        held_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (accept) begin
      held_instr <= instr_i;
    end
  end

  assign instr_o    = held_instr;
  assign valid_o    = held_valid;
  assign rs1_addr_o = held_instr.rs1_addr;
  assign rs2_addr_o = held_instr.rs2_addr;

endmodule

// ==== rtl/issue_skid_buffer.sv ====
`timescale 1ns/1ps

module issue_skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk_core,
  input  logic             rst_core_n,
  input  logic             flush_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic [WIDTH-1:0] data_o,
  output logic             valid_o,
  input  logic             ready_i
);

  logic [WIDTH-1:0] out_data;
  logic             out_valid;
  logic [WIDTH-1:0] skid_data;
  logic             skid_valid;
  logic             in_take;
  logic             out_free;

  // Ready comes straight from a flop
  assign ready_o  = ~skid_valid;
  assign in_take  = valid_i & ~skid_valid;
  assign out_free = ~out_valid | ready_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (flush_i) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Skid entry drains first to keep order
      out_valid  <= skid_valid | in_take;
      skid_valid <= 1'b0;
    end else if (in_take) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (out_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_take) begin
        out_data <= data_i;
      end
    end else if (in_take) begin
      skid_data <= data_i;
    end
  end

  assign data_o  = out_data;
  assign valid_o = out_valid;

endmodule

// ==== rtl/issue_stage.sv ====
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_stage (
  input  logic                         clk_core,
  input  logic                         rst_core_n,
  input  logic                         flush_req_i,
  output logic                         flush_ack_o,
  input  issue_pkg::issue_instr_t      issue_instr_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  output issue_pkg::alu_data_t         alu_data_o,
  output logic                         alu_valid_o,
  input  logic                         alu_ready_i,
  output issue_pkg::branch_data_t      branch_data_o,
  output logic                         branch_valid_o,
  input  logic                         branch_ready_i,
  output issue_pkg::mem_data_t         mem_data_o,
  output logic                         mem_valid_o,
  input  logic                         mem_ready_i,
  input  logic                         wr_en_i,
  input  logic [`ISSUE_REG_ADDR_W-1:0] wr_addr_i,
  input  logic [`ISSUE_XLEN-1:0]       wr_data_i
);

  // Hold stage to dispatch
  issue_pkg::issue_instr_t      s1_instr;
  logic                         s1_advance;
  logic                         dispatch_free;
  logic [`ISSUE_REG_ADDR_W-1:0] rs1_addr;
  logic [`ISSUE_REG_ADDR_W-1:0] rs2_addr;
  logic [`ISSUE_XLEN-1:0]       rs1_data;
  logic [`ISSUE_XLEN-1:0]       rs2_data;

  // Dispatch to the unit buffers
  issue_pkg::alu_data_t    d_alu_data;
  issue_pkg::branch_data_t d_branch_data;
  issue_pkg::mem_data_t    d_mem_data;
  logic                    d_alu_valid;
  logic                    d_branch_valid;
  logic                    d_mem_valid;
  logic                    alu_buf_ready;
  logic                    branch_buf_ready;
  logic                    mem_buf_ready;

  issue_regfile regfile_inst (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .wr_en_i    (wr_en_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  issue_scoreboard scoreboard_inst (
    .clk_core        (clk_core),
    .rst_core_n      (rst_core_n),
    .flush_i         (flush_req_i),
    .instr_i         (issue_instr_i),
    .valid_i         (valid_i),
    .ready_o         (ready_o),
    .dispatch_free_i (dispatch_free),
    .wr_en_i         (wr_en_i),
    .wr_addr_i       (wr_addr_i),
    .instr_o         (s1_instr),
    .valid_o         (),
    .advance_o       (s1_advance),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr)
  );

  issue_dispatch dispatch_inst (
    .clk_core       (clk_core),
    .rst_core_n     (rst_core_n),
    .flush_i        (flush_req_i),
    .instr_i        (s1_instr),
    .advance_i      (s1_advance),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .alu_ready_i    (alu_buf_ready),
    .branch_ready_i (branch_buf_ready),
    .mem_ready_i    (mem_buf_ready),
    .free_o         (dispatch_free),
    .alu_data_o     (d_alu_data),
    .alu_valid_o    (d_alu_valid),
    .branch_data_o  (d_branch_data),
    .branch_valid_o (d_branch_valid),
    .mem_data_o     (d_mem_data),
    .mem_valid_o    (d_mem_valid)
  );

  issue_skid_buffer #(
    .WIDTH ($bits(issue_pkg::alu_data_t))
  ) alu_buf_inst (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (d_alu_data),
    .valid_i    (d_alu_valid),
    .ready_o    (alu_buf_ready),
    .data_o     (alu_data_o),
    .valid_o    (alu_valid_o),
    .ready_i    (alu_ready_i)
  );

  issue_skid_buffer #(
    .WIDTH ($bits(issue_pkg::branch_data_t))
  ) branch_buf_inst (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (d_branch_data),
    .valid_i    (d_branch_valid),
    .ready_o    (branch_buf_ready),
    .data_o     (branch_data_o),
    .valid_o    (branch_valid_o),
    .ready_i    (branch_ready_i)
  );

  issue_skid_buffer #(
    .WIDTH ($bits(issue_pkg::mem_data_t))
  ) mem_buf_inst (
    .clk_core   (clk_core),
    .rst_core_n (rst_core_n),
    .flush_i    (flush_req_i),
    .data_i     (d_mem_data),
    .valid_i    (d_mem_valid),
    .ready_o    (mem_buf_ready),
    .data_o     (mem_data_o),
    .valid_o    (mem_valid_o),
    .ready_i    (mem_ready_i)
  );

  // Flush completes in one cycle everywhere
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
    end
  end

endmodule

// ==== verif/issue_tb.sv ====
`timescale 1ns/1ps
`include "issue_cfg.svh"

module issue_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DELAY = 10;
  localparam int NUM_TESTS   = 5;
  localparam int OUT_LIMIT   = 20;
  // Unit valid rises after edge k+2, so the unit takes it at edge k+3
  localparam int TAKE_CYCLES = 3;

  logic                          clk_core;
  logic                          rst_core_n;
  logic                          flush_req_i;
  logic                          flush_ack_o;
  issue_pkg::issue_instr_t       issue_instr_i;
  logic                          valid_i;
  logic                          ready_o;
  issue_pkg::alu_data_t          alu_data_o;
  logic                          alu_valid_o;
  logic                          alu_ready_i;
  issue_pkg::branch_data_t       branch_data_o;
  logic                          branch_valid_o;
  logic                          branch_ready_i;
  issue_pkg::mem_data_t          mem_data_o;
  logic                          mem_valid_o;
  logic                          mem_ready_i;
  logic                          wr_en_i;
  logic [`ISSUE_REG_ADDR_W-1:0]  wr_addr_i;
  logic [`ISSUE_XLEN-1:0]        wr_data_i;

  // Register contents as the testbench expects them
  logic [`ISSUE_XLEN-1:0] model_regs [`ISSUE_REG_COUNT];

  // Payloads taken by each unit, in order
  issue_pkg::alu_data_t    alu_q [$];
  issue_pkg::branch_data_t branch_q [$];
  issue_pkg::mem_data_t    mem_q [$];

  int          error_count;
  int          tests_passed;
  int          tests_failed;

  issue_stage issue_stage_inst (
    .clk_core       (clk_core),
    .rst_core_n     (rst_core_n),
    .flush_req_i    (flush_req_i),
    .flush_ack_o    (flush_ack_o),
    .issue_instr_i  (issue_instr_i),
    .valid_i        (valid_i),
    .ready_o        (ready_o),
    .alu_data_o     (alu_data_o),
    .alu_valid_o    (alu_valid_o),
    .alu_ready_i    (alu_ready_i),
    .branch_data_o  (branch_data_o),
    .branch_valid_o (branch_valid_o),
    .branch_ready_i (branch_ready_i),
    .mem_data_o     (mem_data_o),
    .mem_valid_o    (mem_valid_o),
    .mem_ready_i    (mem_ready_i),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_data_i      (wr_data_i)
  );

  always #(CLK_PERIOD / 2) clk_core = ~clk_core;

  // Inputs only move after the rising edge, so the falling edge sees the coming transfer
  always @(negedge clk_core) begin
    if (alu_valid_o && alu_ready_i) begin
      alu_q.push_back(alu_data_o);
    end
    if (branch_valid_o && branch_ready_i) begin
      branch_q.push_back(branch_data_o);
    end
    if (mem_valid_o && mem_ready_i) begin
      mem_q.push_back(mem_data_o);
    end
  end

  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Errors found");
    $finish;
  end

  task automatic report_mismatch(input string name, input logic [159:0] got,
                                 input logic [159:0] exp);
    $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("Failure: %s", msg);
    error_count++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: FAIL with %0d failed checks", name, error_count - errs_before);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk_core);
    #DRIVE_DELAY;
  endtask

  function automatic int rand_reg();
    return 1 + ($urandom() % (`ISSUE_REG_COUNT - 1));
  endfunction

  // x0 always reads as zero
  function automatic logic [`ISSUE_XLEN-1:0] model_read(input int addr);
    if (addr == 0) begin
      return '0;
    end
    return model_regs[addr];
  endfunction

  function automatic issue_pkg::issue_instr_t make_instr(input issue_pkg::unit_e unit,
      input int op, input logic writes_rd, input int rd, input int rs1, input int rs2);
    issue_pkg::issue_instr_t ins;
    ins.unit      = unit;
    ins.op        = op[2:0];
    ins.writes_rd = writes_rd;
    ins.rd_addr   = rd[`ISSUE_REG_ADDR_W-1:0];
    ins.rs1_addr  = rs1[`ISSUE_REG_ADDR_W-1:0];
    ins.rs2_addr  = rs2[`ISSUE_REG_ADDR_W-1:0];
    ins.pc        = $urandom() & 32'hffff_fffc;
    ins.imm       = $urandom();
    ins.use_imm   = $urandom() % 2;
    return ins;
  endfunction

  function automatic int queue_len(input issue_pkg::unit_e unit);
    case (unit)
      issue_pkg::UNIT_ALU:    return alu_q.size();
      issue_pkg::UNIT_BRANCH: return branch_q.size();
      default:                return mem_q.size();
    endcase
  endfunction

  task automatic write_reg(input int addr, input logic [`ISSUE_XLEN-1:0] data);
    wr_en_i   = 1'b1;
    wr_addr_i = addr[`ISSUE_REG_ADDR_W-1:0];
    wr_data_i = data;
    if (addr != 0) begin
      model_regs[addr] = data;
    end
    step_cycle();
    wr_en_i = 1'b0;
  endtask

  // Returns at the drive point after the acceptance edge
  task automatic send_instr(input issue_pkg::issue_instr_t ins);
    int waited;
    issue_instr_i = ins;
    valid_i       = 1'b1;
    waited        = 0;
    @(negedge clk_core);
    while (!ready_o && waited < OUT_LIMIT) begin
      @(negedge clk_core);
      waited++;
    end
    if (!ready_o) begin
      report_failure("ready_o stayed low, the instruction was never accepted");
    end
    step_cycle();
    valid_i = 1'b0;
  endtask

  task automatic expect_unit(input issue_pkg::unit_e unit, input issue_pkg::issue_instr_t ins,
                             input int limit, output int waited);
    issue_pkg::exec_common_t common;
    issue_pkg::alu_data_t    alu_exp;
    issue_pkg::branch_data_t branch_exp;
    issue_pkg::mem_data_t    mem_exp;
    issue_pkg::alu_data_t    alu_got;
    issue_pkg::branch_data_t branch_got;
    issue_pkg::mem_data_t    mem_got;
    common.rs1        = model_read(ins.rs1_addr);
    common.rs2        = model_read(ins.rs2_addr);
    common.pc         = ins.pc;
    common.imm        = ins.imm;
    common.rd_addr    = ins.rd_addr;
    alu_exp.op        = issue_pkg::alu_op_e'(ins.op);
    alu_exp.use_imm   = ins.use_imm;
    alu_exp.common    = common;
    branch_exp.op        = issue_pkg::branch_op_e'(ins.op);
    branch_exp.writes_rd = ins.writes_rd;
    branch_exp.common    = common;
    mem_exp.op        = issue_pkg::mem_op_e'(ins.op);
    mem_exp.writes_rd = ins.writes_rd;
    mem_exp.common    = common;
    waited = 0;
    while (queue_len(unit) == 0 && waited < limit) begin
      step_cycle();
      waited++;
    end
    if (queue_len(unit) == 0) begin
      report_failure($sformatf("nothing came out on the %s port within %0d cycles",
                               unit.name(), limit));
      return;
    end
    case (unit)
      issue_pkg::UNIT_ALU: begin
        alu_got = alu_q.pop_front();
        if (alu_got !== alu_exp) report_mismatch("alu_data_o", alu_got, alu_exp);
      end
      issue_pkg::UNIT_BRANCH: begin
        branch_got = branch_q.pop_front();
        if (branch_got !== branch_exp) report_mismatch("branch_data_o", branch_got, branch_exp);
      end
      default: begin
        mem_got = mem_q.pop_front();
        if (mem_got !== mem_exp) report_mismatch("mem_data_o", mem_got, mem_exp);
      end
    endcase
  endtask

  task automatic test_reset_state();
    int errs_before;
    errs_before = error_count;
    if (ready_o !== 1'b1) report_mismatch("ready_o", ready_o, 1'b1);
    if (alu_valid_o !== 1'b0) report_mismatch("alu_valid_o", alu_valid_o, 1'b0);
    if (branch_valid_o !== 1'b0) report_mismatch("branch_valid_o", branch_valid_o, 1'b0);
    if (mem_valid_o !== 1'b0) report_mismatch("mem_valid_o", mem_valid_o, 1'b0);
    if (flush_ack_o !== 1'b0) report_mismatch("flush_ack_o", flush_ack_o, 1'b0);
    finish_test("reset_state", errs_before);
  endtask

  task automatic test_routing();
    int                      errs_before;
    int                      waited;
    issue_pkg::issue_instr_t ins [3];
    errs_before = error_count;
    // x0 ignores writes and keeps reading zero
    write_reg(0, $urandom() | 32'h1);
    for (int r = 1; r < `ISSUE_REG_COUNT; r++) begin
      write_reg(r, $urandom());
    end
    // rs2 of the ALU and rs1 of the branch read x0
    ins[0] = make_instr(issue_pkg::UNIT_ALU, $urandom() % 8, 1'b0, rand_reg(), rand_reg(), 0);
    ins[1] = make_instr(issue_pkg::UNIT_BRANCH, $urandom() % 6, 1'b0, rand_reg(), 0, rand_reg());
    ins[2] = make_instr(issue_pkg::UNIT_MEM, $urandom() % 6, 1'b0, rand_reg(), rand_reg(),
                        rand_reg());
    for (int i = 0; i < 3; i++) begin
      send_instr(ins[i]);
      expect_unit(ins[i].unit, ins[i], OUT_LIMIT, waited);
      if (waited != TAKE_CYCLES) begin
        report_failure($sformatf("%s output took %0d cycles instead of %0d",
                                 ins[i].unit.name(), waited, TAKE_CYCLES));
      end
      if (alu_q.size() + branch_q.size() + mem_q.size() != 0) begin
        report_failure("an instruction also appeared on a port other than its own");
      end
    end
    finish_test("routing", errs_before);
  endtask

  task automatic test_raw_hazard();
    int                      errs_before;
    int                      waited;
    issue_pkg::issue_instr_t writer;
    issue_pkg::issue_instr_t reader;
    errs_before = error_count;
    writer = make_instr(issue_pkg::UNIT_ALU, $urandom() % 8, 1'b1, 5, rand_reg(), rand_reg());
    reader = make_instr(issue_pkg::UNIT_MEM, $urandom() % 6, 1'b0, rand_reg(), 5, rand_reg());
    send_instr(writer);
    send_instr(reader);
    repeat (6) step_cycle();
    expect_unit(issue_pkg::UNIT_ALU, writer, OUT_LIMIT, waited);
    if (mem_q.size() != 0) begin
      report_failure("the reader of r5 issued while r5 was still pending");
    end
    write_reg(5, $urandom());
    expect_unit(issue_pkg::UNIT_MEM, reader, OUT_LIMIT, waited);
    finish_test("raw_hazard", errs_before);
  endtask

  task automatic test_back_pressure();
    int                      errs_before;
    int                      waited;
    int                      n;
    logic                    fell;
    issue_pkg::issue_instr_t ins [5];
    errs_before = error_count;
    alu_ready_i = 1'b0;
    for (int i = 0; i < 5; i++) begin
      ins[i] = make_instr(issue_pkg::UNIT_ALU, $urandom() % 8, 1'b0, rand_reg(), rand_reg(),
                          rand_reg());
    end
    for (int i = 0; i < 4; i++) begin
      send_instr(ins[i]);
    end
    issue_instr_i = ins[4];
    valid_i       = 1'b1;
    fell          = 1'b0;
    n             = 0;
    while (!fell && n < 10) begin
      @(negedge clk_core);
      fell = !ready_o;
      n++;
    end
    step_cycle();
    if (!fell) report_failure("ready_o never fell while the ALU port was stalled");
    if (alu_valid_o !== 1'b1) report_mismatch("alu_valid_o", alu_valid_o, 1'b1);
    alu_ready_i = 1'b1;
    send_instr(ins[4]);
    for (int i = 0; i < 5; i++) begin
      expect_unit(issue_pkg::UNIT_ALU, ins[i], OUT_LIMIT, waited);
    end
    finish_test("back_pressure", errs_before);
  endtask

  task automatic test_flush();
    int                      errs_before;
    int                      waited;
    issue_pkg::issue_instr_t writer;
    issue_pkg::issue_instr_t reader;
    issue_pkg::issue_instr_t late_reader;
    errs_before = error_count;
    alu_ready_i = 1'b0;
    writer = make_instr(issue_pkg::UNIT_ALU, $urandom() % 8, 1'b1, 7, rand_reg(), rand_reg());
    reader = make_instr(issue_pkg::UNIT_BRANCH, $urandom() % 6, 1'b0, rand_reg(), 7, rand_reg());
    send_instr(writer);
    send_instr(reader);
    repeat (3) step_cycle();
    flush_req_i = 1'b1;
    @(negedge clk_core);
    if (flush_ack_o !== 1'b0) report_mismatch("flush_ack_o", flush_ack_o, 1'b0);
    step_cycle();
    flush_req_i = 1'b0;
    if (flush_ack_o !== 1'b1) report_mismatch("flush_ack_o", flush_ack_o, 1'b1);
    step_cycle();
    if (flush_ack_o !== 1'b0) report_mismatch("flush_ack_o", flush_ack_o, 1'b0);
    alu_ready_i = 1'b1;
    repeat (6) step_cycle();
    if (alu_q.size() + branch_q.size() + mem_q.size() != 0) begin
      report_failure("a flushed instruction came out after the flush");
    end
    // r7 was pending before the flush and is never written back
    late_reader = make_instr(issue_pkg::UNIT_MEM, $urandom() % 6, 1'b0, rand_reg(), 7,
                             rand_reg());
    send_instr(late_reader);
    expect_unit(issue_pkg::UNIT_MEM, late_reader, OUT_LIMIT, waited);
    finish_test("flush", errs_before);
  endtask

  initial begin
    void'($urandom(32'hce7e_53b3));
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    clk_core       = 1'b0;
    rst_core_n     = 1'b0;
    flush_req_i    = 1'b0;
    issue_instr_i  = '0;
    valid_i        = 1'b0;
    alu_ready_i    = 1'b1;
    branch_ready_i = 1'b1;
    mem_ready_i    = 1'b1;
    wr_en_i        = 1'b0;
    wr_addr_i      = '0;
    wr_data_i      = '0;
    for (int r = 0; r < `ISSUE_REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    repeat (5) @(posedge clk_core);
    #DRIVE_DELAY;
    rst_core_n = 1'b1;

    test_reset_state();
    test_routing();
    test_raw_hazard();
    test_back_pressure();
    test_flush();

    $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/issue_pkg.sv
rtl/issue_regfile.sv
rtl/issue_scoreboard.sv
rtl/issue_dispatch.sv
rtl/issue_skid_buffer.sv
rtl/issue_stage.sv
verif/issue_tb.sv
